//--- src/riscv_pkg.sv
package riscv_pkg;

  typedef logic [31:0] word_t;

  // Major opcodes, low two bits always 11.
  localparam logic [6:0] LOAD     = 7'b00000_11;
  localparam logic [6:0] MISC_MEM = 7'b00011_11;
  localparam logic [6:0] OP_IMM   = 7'b00100_11;
  localparam logic [6:0] AUIPC    = 7'b00101_11;
  localparam logic [6:0] STORE    = 7'b01000_11;
  localparam logic [6:0] OP       = 7'b01100_11;
  localparam logic [6:0] LUI      = 7'b01101_11;
  localparam logic [6:0] BRANCH   = 7'b11000_11;
  localparam logic [6:0] JALR     = 7'b11001_11;
  localparam logic [6:0] JAL      = 7'b11011_11;
  localparam logic [6:0] SYSTEM   = 7'b11100_11;

  // Top two bits pick the group, low three follow funct3.
  typedef logic [4:0] alu_op_t;

  localparam alu_op_t ALU_ADD  = 5'b00_000;
  localparam alu_op_t ALU_SLL  = 5'b00_001;
  localparam alu_op_t ALU_SLTS = 5'b00_010;
  localparam alu_op_t ALU_SLTU = 5'b00_011;
  localparam alu_op_t ALU_XOR  = 5'b00_100;
  localparam alu_op_t ALU_SRL  = 5'b00_101;
  localparam alu_op_t ALU_OR   = 5'b00_110;
  localparam alu_op_t ALU_AND  = 5'b00_111;
  localparam alu_op_t ALU_SUB  = 5'b01_000;
  localparam alu_op_t ALU_SRA  = 5'b01_101;
  localparam alu_op_t ALU_EQ   = 5'b11_000;
  localparam alu_op_t ALU_NE   = 5'b11_001;
  localparam alu_op_t ALU_LTS  = 5'b11_100;
  localparam alu_op_t ALU_GES  = 5'b11_101;
  localparam alu_op_t ALU_LTU  = 5'b11_110;
  localparam alu_op_t ALU_GEU  = 5'b11_111;

  typedef logic [1:0] op_a_sel_t;

  localparam op_a_sel_t OP_A_RS1     = 2'd0;
  localparam op_a_sel_t OP_A_CURR_PC = 2'd1;
  localparam op_a_sel_t OP_A_ZERO    = 2'd2;

  typedef logic [2:0] op_b_sel_t;

  localparam op_b_sel_t OP_B_RS2   = 3'd0;
  localparam op_b_sel_t OP_B_IMM_I = 3'd1;
  localparam op_b_sel_t OP_B_IMM_U = 3'd2;
  localparam op_b_sel_t OP_B_IMM_S = 3'd3;
  // Constant 4.
  localparam op_b_sel_t OP_B_INCR  = 3'd4;

  typedef logic wb_sel_t;

  localparam wb_sel_t WB_EX_RESULT = 1'b0;
  localparam wb_sel_t WB_LSU_DATA  = 1'b1;

  // Same encoding as funct3 of loads and stores.
  typedef logic [2:0] ldst_size_t;

  localparam ldst_size_t LDST_B  = 3'b000;
  localparam ldst_size_t LDST_H  = 3'b001;
  localparam ldst_size_t LDST_W  = 3'b010;
  localparam ldst_size_t LDST_BU = 3'b100;
  localparam ldst_size_t LDST_HU = 3'b101;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_type_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_type_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_type_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_type_t;

  typedef union packed {
    r_type_t r;
    i_type_t i;
    s_type_t s;
    b_type_t b;
    u_type_t u;
    j_type_t j;
  } instr_u;

endpackage

//--- src/lsu_core_if.sv
interface lsu_core_if;

  logic                  req;
  logic                  we;
  riscv_pkg::ldst_size_t size;
  riscv_pkg::word_t      addr;
  riscv_pkg::word_t      wdata;
  riscv_pkg::word_t      rdata;
  logic                  stall;

  modport core (
    output req, we, size, addr, wdata,
    input  rdata, stall
  );

  modport lsu (
    input  req, we, size, addr, wdata,
    output rdata, stall
  );

endinterface

//--- src/decoder_riscv.sv
module decoder_riscv (
  input  riscv_pkg::instr_u     fetched_instr_i,
  input  logic                  lsu_stall_req_i,
  output riscv_pkg::op_a_sel_t  ex_op_a_sel_o,
  output riscv_pkg::op_b_sel_t  ex_op_b_sel_o,
  output riscv_pkg::alu_op_t    alu_op_o,
  output logic                  mem_req_o,
  output logic                  mem_we_o,
  output riscv_pkg::ldst_size_t mem_size_o,
  output logic                  gpr_we_a_o,
  output riscv_pkg::wb_sel_t    wb_src_sel_o,
  output logic                  illegal_instr_o,
  output logic                  branch_o,
  output logic                  jal_o,
  output logic                  jalr_o,
  output logic                  enpc_o
);

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [24:0] sys_field;

  assign opcode    = fetched_instr_i.r.opcode;
  assign funct3    = fetched_instr_i.r.funct3;
  assign funct7    = fetched_instr_i.r.funct7;
  assign sys_field = fetched_instr_i[31:7];

  // Hold the PC while the LSU is busy.
  assign enpc_o = ~lsu_stall_req_i;

  always_comb begin
    ex_op_a_sel_o   = riscv_pkg::OP_A_RS1;
    ex_op_b_sel_o   = riscv_pkg::OP_B_IMM_I;
    alu_op_o        = riscv_pkg::ALU_ADD;
    mem_req_o       = 1'b0;
    mem_we_o        = 1'b0;
    mem_size_o      = riscv_pkg::LDST_B;
    gpr_we_a_o      = 1'b0;
    wb_src_sel_o    = riscv_pkg::WB_EX_RESULT;
    illegal_instr_o = 1'b0;
    branch_o        = 1'b0;
    jal_o           = 1'b0;
    jalr_o          = 1'b0;

    case (opcode)
      riscv_pkg::LOAD: begin
        mem_req_o    = 1'b1;
        mem_size_o   = funct3;
        gpr_we_a_o   = 1'b1;
        wb_src_sel_o = riscv_pkg::WB_LSU_DATA;
        if (funct3 == 3'b011 || funct3 == 3'b110 || funct3 == 3'b111) begin
          illegal_instr_o = 1'b1;
          mem_size_o      = riscv_pkg::LDST_B;
        end
      end

      // FENCE does nothing here.
      riscv_pkg::MISC_MEM: begin
      end

      riscv_pkg::OP_IMM: begin
        alu_op_o   = {2'b00, funct3};
        gpr_we_a_o = 1'b1;
        if (funct3 == 3'b001) begin
          illegal_instr_o = (funct7 != F7_BASE);
        end else if (funct3 == 3'b101) begin
          if (funct7 == F7_ALT) begin
            alu_op_o = {2'b01, funct3};
          end else if (funct7 != F7_BASE) begin
            illegal_instr_o = 1'b1;
          end
        end
      end

      riscv_pkg::AUIPC: begin
        ex_op_a_sel_o = riscv_pkg::OP_A_CURR_PC;
        ex_op_b_sel_o = riscv_pkg::OP_B_IMM_U;
        gpr_we_a_o    = 1'b1;
      end

      riscv_pkg::STORE: begin
        ex_op_b_sel_o = riscv_pkg::OP_B_IMM_S;
        mem_req_o     = 1'b1;
        mem_we_o      = 1'b1;
        mem_size_o    = funct3;
        wb_src_sel_o  = riscv_pkg::WB_LSU_DATA;
        if (funct3 != riscv_pkg::LDST_B && funct3 != riscv_pkg::LDST_H &&
            funct3 != riscv_pkg::LDST_W) begin
          illegal_instr_o = 1'b1;
          mem_size_o      = riscv_pkg::LDST_B;
        end
      end

      riscv_pkg::OP: begin
        ex_op_b_sel_o = riscv_pkg::OP_B_RS2;
        alu_op_o      = {2'b00, funct3};
        gpr_we_a_o    = 1'b1;
        // Only ADD and SRL have an alternate form.
        if (funct7 == F7_ALT) begin
          alu_op_o = {2'b01, funct3};
          if (funct3 != 3'b000 && funct3 != 3'b101) begin
            illegal_instr_o = 1'b1;
          end
        end else if (funct7 != F7_BASE) begin
          illegal_instr_o = 1'b1;
        end
      end

      riscv_pkg::LUI: begin
        ex_op_a_sel_o = riscv_pkg::OP_A_ZERO;
        ex_op_b_sel_o = riscv_pkg::OP_B_IMM_U;
        gpr_we_a_o    = 1'b1;
      end

      riscv_pkg::BRANCH: begin
        ex_op_b_sel_o = riscv_pkg::OP_B_RS2;
        alu_op_o      = {2'b11, funct3};
        branch_o      = 1'b1;
        if (funct3 == 3'b010 || funct3 == 3'b011) begin
          illegal_instr_o = 1'b1;
          alu_op_o        = riscv_pkg::ALU_EQ;
        end
      end

      // Link value is PC plus 4, the target is computed in the core.
      riscv_pkg::JALR: begin
        ex_op_a_sel_o   = riscv_pkg::OP_A_CURR_PC;
        ex_op_b_sel_o   = riscv_pkg::OP_B_INCR;
        gpr_we_a_o      = 1'b1;
        jalr_o          = 1'b1;
        illegal_instr_o = (funct3 != 3'b000);
      end

      riscv_pkg::JAL: begin
        ex_op_a_sel_o = riscv_pkg::OP_A_CURR_PC;
        ex_op_b_sel_o = riscv_pkg::OP_B_INCR;
        gpr_we_a_o    = 1'b1;
        jal_o         = 1'b1;
      end

      // ECALL and EBREAK have no trap support.
      riscv_pkg::SYSTEM: begin
        if (sys_field == 25'd0 || sys_field == {12'd1, 13'd0}) begin
          illegal_instr_o = 1'b1;
        end
      end

      default: begin
        illegal_instr_o = 1'b1;
      end
    endcase

    // At most one control transfer kind per instruction.
    assert ($onehot0({branch_o, jal_o, jalr_o}))
      else $error("decoder: more than one control transfer flag set");
  end

endmodule

//--- src/alu_riscv.sv
module alu_riscv (
  input  riscv_pkg::alu_op_t operator_i,
  input  riscv_pkg::word_t   operand_a_i,
  input  riscv_pkg::word_t   operand_b_i,
  output riscv_pkg::word_t   result_o,
  output logic               flag_o
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = operand_b_i[4:0];
  assign lt_signed   = $signed(operand_a_i) < $signed(operand_b_i);
  assign lt_unsigned = operand_a_i < operand_b_i;

  always_comb begin
    result_o = '0;
    flag_o   = 1'b0;
    case (operator_i)
      riscv_pkg::ALU_ADD:  result_o = operand_a_i + operand_b_i;
      riscv_pkg::ALU_SUB:  result_o = operand_a_i - operand_b_i;
      riscv_pkg::ALU_SLL:  result_o = operand_a_i << shamt;
      riscv_pkg::ALU_SLTS: result_o = {31'd0, lt_signed};
      riscv_pkg::ALU_SLTU: result_o = {31'd0, lt_unsigned};
      riscv_pkg::ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      riscv_pkg::ALU_SRL:  result_o = operand_a_i >> shamt;
      riscv_pkg::ALU_SRA:  result_o = $signed(operand_a_i) >>> shamt;
      riscv_pkg::ALU_OR:   result_o = operand_a_i | operand_b_i;
      riscv_pkg::ALU_AND:  result_o = operand_a_i & operand_b_i;
      // Comparisons leave the result at zero.
      riscv_pkg::ALU_EQ:   flag_o = (operand_a_i == operand_b_i);
      riscv_pkg::ALU_NE:   flag_o = (operand_a_i != operand_b_i);
      riscv_pkg::ALU_LTS:  flag_o = lt_signed;
      riscv_pkg::ALU_GES:  flag_o = ~lt_signed;
      riscv_pkg::ALU_LTU:  flag_o = lt_unsigned;
      riscv_pkg::ALU_GEU:  flag_o = ~lt_unsigned;
      default: begin
      end
    endcase
  end

endmodule

//--- src/rf_riscv.sv
module rf_riscv (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic [4:0]       ra1_i,
  input  logic [4:0]       ra2_i,
  input  logic [4:0]       wa_i,
  input  logic             we_i,
  input  riscv_pkg::word_t wd_i,
  output riscv_pkg::word_t rd1_o,
  output riscv_pkg::word_t rd2_o
);

  riscv_pkg::word_t regs [32];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && wa_i != 5'd0) begin
      regs[wa_i] <= wd_i;
    end
  end

  // x0 always reads as zero.
  assign rd1_o = (ra1_i == 5'd0) ? '0 : regs[ra1_i];
  assign rd2_o = (ra2_i == 5'd0) ? '0 : regs[ra2_i];

endmodule

//--- src/lsu_riscv.sv
module lsu_riscv (
  input  logic             clk_i,
  input  logic             rst_i,
  lsu_core_if.lsu          core,
  output logic             mem_req_o,
  output logic             mem_we_o,
  output logic [3:0]       mem_be_o,
  output riscv_pkg::word_t mem_addr_o,
  output riscv_pkg::word_t mem_wdata_o,
  input  riscv_pkg::word_t mem_rdata_i
);

  logic        done_q;
  logic [1:0]  offset;
  logic [7:0]  byte_lane;
  logic [15:0] half_lane;

  assign offset = core.addr[1:0];

  // First cycle of an access stalls, the second finishes it.
  assign core.stall = core.req & ~done_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      done_q <= 1'b0;
    end else begin
      done_q <= core.stall;
    end
  end

  assign mem_req_o  = core.stall;
  assign mem_we_o   = core.stall & core.we;
  assign mem_addr_o = {core.addr[31:2], 2'b00};

  // Replicate store data over all lanes.
  always_comb begin
    case (core.size[1:0])
      2'b00: begin
        mem_be_o    = 4'b0001 << offset;
        mem_wdata_o = {4{core.wdata[7:0]}};
      end
      2'b01: begin
        mem_be_o    = offset[1] ? 4'b1100 : 4'b0011;
        mem_wdata_o = {2{core.wdata[15:0]}};
      end
      default: begin
        mem_be_o    = 4'b1111;
        mem_wdata_o = core.wdata;
      end
    endcase
  end

  assign byte_lane = mem_rdata_i[{offset, 3'b000} +: 8];
  assign half_lane = offset[1] ? mem_rdata_i[31:16] : mem_rdata_i[15:0];

  always_comb begin
    case (core.size)
      riscv_pkg::LDST_B:  core.rdata = {{24{byte_lane[7]}}, byte_lane};
      riscv_pkg::LDST_H:  core.rdata = {{16{half_lane[15]}}, half_lane};
      riscv_pkg::LDST_BU: core.rdata = {24'd0, byte_lane};
      riscv_pkg::LDST_HU: core.rdata = {16'd0, half_lane};
      default:            core.rdata = mem_rdata_i;
    endcase
  end

  // Each access issues a single request cycle.
  assert property (@(posedge clk_i) disable iff (rst_i) mem_req_o |=> !mem_req_o)
    else $error("lsu: memory request held for two cycles");

endmodule

//--- src/riscv_core.sv
module riscv_core #(
  parameter riscv_pkg::word_t RESET_ADDR = 32'h0000_0000
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  riscv_pkg::word_t instr_i,
  output riscv_pkg::word_t instr_addr_o,
  output logic             mem_req_o,
  output logic             mem_we_o,
  output logic [3:0]       mem_be_o,
  output riscv_pkg::word_t mem_addr_o,
  output riscv_pkg::word_t mem_wdata_o,
  input  riscv_pkg::word_t mem_rdata_i,
  output logic             illegal_instr_o
);

  riscv_pkg::instr_u     instr;
  riscv_pkg::word_t      pc_q;
  riscv_pkg::word_t      pc_next;
  riscv_pkg::word_t      imm_i;
  riscv_pkg::word_t      imm_s;
  riscv_pkg::word_t      imm_b;
  riscv_pkg::word_t      imm_u;
  riscv_pkg::word_t      imm_j;
  riscv_pkg::word_t      rd1;
  riscv_pkg::word_t      rd2;
  riscv_pkg::word_t      op_a;
  riscv_pkg::word_t      op_b;
  riscv_pkg::word_t      alu_result;
  riscv_pkg::word_t      wb_data;
  riscv_pkg::op_a_sel_t  op_a_sel;
  riscv_pkg::op_b_sel_t  op_b_sel;
  riscv_pkg::alu_op_t    alu_op;
  riscv_pkg::ldst_size_t mem_size;
  riscv_pkg::wb_sel_t    wb_sel;
  logic                  dec_mem_req;
  logic                  dec_mem_we;
  logic                  gpr_we;
  logic                  illegal;
  logic                  branch;
  logic                  jal;
  logic                  jalr;
  logic                  enpc;
  logic                  alu_flag;
  logic                  rf_we;

  lsu_core_if lsu_bus ();

  assign instr = instr_i;

  assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
  assign imm_s = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
  assign imm_b = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                  instr.b.imm10_5, instr.b.imm4_1, 1'b0};
  assign imm_u = {instr.u.imm, 12'd0};
  assign imm_j = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                  instr.j.imm11, instr.j.imm10_1, 1'b0};

  decoder_riscv u_decoder (
    .fetched_instr_i (instr),
    .lsu_stall_req_i (lsu_bus.stall),
    .ex_op_a_sel_o   (op_a_sel),
    .ex_op_b_sel_o   (op_b_sel),
    .alu_op_o        (alu_op),
    .mem_req_o       (dec_mem_req),
    .mem_we_o        (dec_mem_we),
    .mem_size_o      (mem_size),
    .gpr_we_a_o      (gpr_we),
    .wb_src_sel_o    (wb_sel),
    .illegal_instr_o (illegal),
    .branch_o        (branch),
    .jal_o           (jal),
    .jalr_o          (jalr),
    .enpc_o          (enpc)
  );

  always_comb begin
    case (op_a_sel)
      riscv_pkg::OP_A_RS1:     op_a = rd1;
      riscv_pkg::OP_A_CURR_PC: op_a = pc_q;
      default:                 op_a = '0;
    endcase
  end

  always_comb begin
    case (op_b_sel)
      riscv_pkg::OP_B_RS2:   op_b = rd2;
      riscv_pkg::OP_B_IMM_I: op_b = imm_i;
      riscv_pkg::OP_B_IMM_U: op_b = imm_u;
      riscv_pkg::OP_B_IMM_S: op_b = imm_s;
      riscv_pkg::OP_B_INCR:  op_b = 32'd4;
      default:               op_b = '0;
    endcase
  end

  alu_riscv u_alu (
    .operator_i  (alu_op),
    .operand_a_i (op_a),
    .operand_b_i (op_b),
    .result_o    (alu_result),
    .flag_o      (alu_flag)
  );

  // Writes only on the last cycle of an instruction.
  assign rf_we   = gpr_we & ~illegal & enpc;
  assign wb_data = (wb_sel == riscv_pkg::WB_LSU_DATA) ? lsu_bus.rdata : alu_result;

  rf_riscv u_rf (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .ra1_i (instr.i.rs1),
    .ra2_i (instr.s.rs2),
    .wa_i  (instr.i.rd),
    .we_i  (rf_we),
    .wd_i  (wb_data),
    .rd1_o (rd1),
    .rd2_o (rd2)
  );

  assign lsu_bus.req   = dec_mem_req & ~illegal;
  assign lsu_bus.we    = dec_mem_we;
  assign lsu_bus.size  = mem_size;
  assign lsu_bus.addr  = alu_result;
  assign lsu_bus.wdata = rd2;

  lsu_riscv u_lsu (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .core        (lsu_bus.lsu),
    .mem_req_o   (mem_req_o),
    .mem_we_o    (mem_we_o),
    .mem_be_o    (mem_be_o),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_rdata_i (mem_rdata_i)
  );

  // Illegal instructions fall through to PC plus 4.
  always_comb begin
    pc_next = pc_q + 32'd4;
    if (!illegal) begin
      if (jalr) begin
        pc_next = (rd1 + imm_i) & ~32'd1;
      end else if (jal) begin
        pc_next = pc_q + imm_j;
      end else if (branch && alu_flag) begin
        pc_next = pc_q + imm_b;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pc_q <= RESET_ADDR;
    end else if (enpc) begin
      pc_q <= pc_next;
    end
  end

  assign instr_addr_o    = pc_q;
  assign illegal_instr_o = illegal;

  // Jump targets must keep the fetch address on a word boundary.
  assert property (@(posedge clk_i) disable iff (rst_i) pc_q[1:0] == 2'b00)
    else $error("core: PC not word-aligned");

endmodule

//--- tb/tb_riscv_core.sv
module tb_riscv_core;
  timeunit 1ns;
  timeprecision 100ps;

  localparam riscv_pkg::word_t RESET_ADDR = 32'h0000_0100;
  localparam int TIMEOUT = 2000;
  localparam riscv_pkg::word_t NOP = 32'h0000_0013;

  logic             clk_i = 1'b0;
  logic             rst_i;
  riscv_pkg::word_t instr_i;
  riscv_pkg::word_t instr_addr_o;
  logic             mem_req_o;
  logic             mem_we_o;
  logic [3:0]       mem_be_o;
  riscv_pkg::word_t mem_addr_o;
  riscv_pkg::word_t mem_wdata_o;
  riscv_pkg::word_t mem_rdata_i = '0;
  logic             illegal_instr_o;

  riscv_pkg::word_t imem [256];
  riscv_pkg::word_t prog [256];
  riscv_pkg::word_t dmem [256];
  riscv_pkg::word_t exp_mem [256];
  riscv_pkg::word_t exp_reg [32];
  riscv_pkg::word_t ill_exp [$];
  riscv_pkg::word_t ill_seen [$];
  riscv_pkg::word_t end_addr;

  int     pc_w;
  int     slot;
  int     n_access;
  int     errors;
  int     req_errors;
  int     req_cycles;
  logic   prev_req;
  integer seed;

  riscv_core #(
    .RESET_ADDR (RESET_ADDR)
  ) UUT (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .instr_i         (instr_i),
    .instr_addr_o    (instr_addr_o),
    .mem_req_o       (mem_req_o),
    .mem_we_o        (mem_we_o),
    .mem_be_o        (mem_be_o),
    .mem_addr_o      (mem_addr_o),
    .mem_wdata_o     (mem_wdata_o),
    .mem_rdata_i     (mem_rdata_i),
    .illegal_instr_o (illegal_instr_o)
  );

  always #2 clk_i = ~clk_i;

  // Instruction memory answers in the same cycle.
  assign instr_i = imem[instr_addr_o[9:2]];

  function automatic riscv_pkg::word_t fill_word(int i);
    logic [7:0] a;
    a = i[7:0];
    return {a ^ 8'hA5, ~a, a, a + 8'h3C};
  endfunction

  // Data memory, reloaded with its fill pattern during reset.
  always @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < 256; i++) begin
        dmem[i] <= fill_word(i);
      end
      mem_rdata_i <= '0;
    end else if (mem_req_o) begin
      if (mem_we_o) begin
        for (int b = 0; b < 4; b++) begin
          if (mem_be_o[b]) begin
            dmem[mem_addr_o[9:2]][8*b +: 8] <= mem_wdata_o[8*b +: 8];
          end
        end
      end
      mem_rdata_i <= dmem[mem_addr_o[9:2]];
    end
  end

  always @(negedge clk_i) begin
    if (rst_i) begin
      req_cycles = 0;
      prev_req = 1'b0;
      ill_seen.delete();
    end else begin
      if (mem_req_o) begin
        req_cycles++;
      end
      if (mem_req_o && prev_req) begin
        $display("memory request stayed high for two cycles at %0t", $time);
        req_errors++;
      end
      if (illegal_instr_o && mem_req_o) begin
        $display("memory request issued for an illegal instruction at %0t", $time);
        req_errors++;
      end
      if (illegal_instr_o) begin
        ill_seen.push_back(instr_addr_o);
      end
      prev_req = mem_req_o;
    end
  end

  task automatic check_word(string name, riscv_pkg::word_t got, riscv_pkg::word_t exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got %b exp %b", $time, name, got, exp);
      errors++;
    end
  endtask

  // Reference results from the RV32I rules.
  function automatic riscv_pkg::word_t alu_ref(logic [2:0] f3, logic alt,
                                               riscv_pkg::word_t a, riscv_pkg::word_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'd0, $signed(a) < $signed(b)};
      3'd3: return {31'd0, a < b};
      3'd4: return a ^ b;
      3'd5: return alt ? riscv_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_ref(logic [2:0] f3, riscv_pkg::word_t a,
                                      riscv_pkg::word_t b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic riscv_pkg::word_t pc_now();
    return RESET_ADDR + 32'(pc_w * 4);
  endfunction

  task automatic emit(riscv_pkg::word_t w);
    riscv_pkg::word_t addr;
    addr = pc_now();
    prog[addr[9:2]] = w;
    pc_w++;
  endtask

  task automatic set_reg(logic [4:0] rd, riscv_pkg::word_t v);
    if (rd != 5'd0) begin
      exp_reg[rd] = v;
    end
  endtask

  task automatic op_r(logic [2:0] f3, logic alt, logic [4:0] rd, logic [4:0] rs1,
                      logic [4:0] rs2);
    emit({alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, riscv_pkg::OP});
    set_reg(rd, alu_ref(f3, alt, exp_reg[rs1], exp_reg[rs2]));
  endtask

  task automatic op_i(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    emit({imm, rs1, f3, rd, riscv_pkg::OP_IMM});
    set_reg(rd, alu_ref(f3, f3 == 3'd5 && imm[10], exp_reg[rs1], {{20{imm[11]}}, imm}));
  endtask

  // LUI plus ADDI, upper part rounded for the sign of the low part.
  task automatic load_const(logic [4:0] rd, riscv_pkg::word_t v);
    riscv_pkg::word_t hi;
    hi = v + 32'h800;
    emit({hi[31:12], rd, riscv_pkg::LUI});
    set_reg(rd, {hi[31:12], 12'd0});
    op_i(3'd0, rd, rd, v[11:0]);
  endtask

  task automatic store(logic [2:0] f3, logic [4:0] rs2, logic [11:0] off);
    emit({off[11:5], rs2, 5'd0, f3, off[4:0], riscv_pkg::STORE});
    n_access++;
    case (f3)
      3'd0: exp_mem[off[9:2]][8*off[1:0] +: 8] = exp_reg[rs2][7:0];
      3'd1: exp_mem[off[9:2]][16*off[1] +: 16] = exp_reg[rs2][15:0];
      default: exp_mem[off[9:2]] = exp_reg[rs2];
    endcase
  endtask

  task automatic load(logic [2:0] f3, logic [4:0] rd, logic [11:0] off);
    riscv_pkg::word_t w;
    logic [7:0]       b;
    logic [15:0]      h;
    w = exp_mem[off[9:2]];
    b = w[8*off[1:0] +: 8];
    h = w[16*off[1] +: 16];
    emit({off, 5'd0, f3, rd, riscv_pkg::LOAD});
    n_access++;
    case (f3)
      3'd0: set_reg(rd, {{24{b[7]}}, b});
      3'd1: set_reg(rd, {{16{h[15]}}, h});
      3'd4: set_reg(rd, {24'd0, b});
      3'd5: set_reg(rd, {16'd0, h});
      default: set_reg(rd, w);
    endcase
  endtask

  task automatic store_slot(logic [4:0] rs2);
    store(3'd2, rs2, 12'(slot * 4));
    slot++;
  endtask

  task automatic start_prog();
    pc_w = 0;
    slot = 64;
    n_access = 0;
    ill_exp.delete();
    for (int i = 0; i < 256; i++) begin
      prog[i] = NOP;
      exp_mem[i] = fill_word(i);
    end
    for (int i = 0; i < 32; i++) begin
      exp_reg[i] = '0;
    end
  endtask

  task automatic reset_dut();
    @(posedge clk_i);
    rst_i <= 1'b1;
    for (int i = 0; i < 10; i++) begin
      @(negedge clk_i);
      if (i == 1) begin
        for (int k = 0; k < 256; k++) begin
          imem[k] = prog[k];
        end
      end
      if (i > 0) begin
        check_word("instr_addr_o", instr_addr_o, RESET_ADDR);
        check_flag("mem_req_o", mem_req_o, 1'b0);
        check_flag("mem_we_o", mem_we_o, 1'b0);
      end
      @(posedge clk_i);
    end
    rst_i <= 1'b0;
    @(negedge clk_i);
    check_word("instr_addr_o", instr_addr_o, RESET_ADDR);
    check_flag("mem_req_o", mem_req_o, 1'b0);
    check_flag("mem_we_o", mem_we_o, 1'b0);
  endtask

  task automatic run_prog(string test);
    int cnt;
    end_addr = pc_now();
    emit({20'd0, 5'd0, riscv_pkg::JAL});
    reset_dut();
    cnt = 0;
    while (instr_addr_o !== end_addr && cnt < TIMEOUT) begin
      @(negedge clk_i);
      cnt++;
    end
    if (instr_addr_o !== end_addr) begin
      $display("%s: timeout, the program never reached its final loop", test);
      errors++;
    end
    for (int i = 0; i < 256; i++) begin
      check_word($sformatf("%s dmem[%0d]", test, i), dmem[i], exp_mem[i]);
    end
    if (req_cycles != n_access) begin
      $display("%s: %0d memory request cycles for %0d accesses", test, req_cycles, n_access);
      errors++;
    end
    if (ill_seen.size() != ill_exp.size()) begin
      $display("%s: %0d illegal instructions flagged, %0d expected", test,
               ill_seen.size(), ill_exp.size());
      errors++;
    end else begin
      foreach (ill_exp[i]) begin
        check_word($sformatf("%s illegal pc", test), ill_seen[i], ill_exp[i]);
      end
    end
  endtask

  task automatic test_alu();
    logic [11:0] imm;
    start_prog();
    load_const(5'd1, $random(seed));
    load_const(5'd2, $random(seed));
    store_slot(5'd1);
    store_slot(5'd2);
    for (int f = 0; f < 8; f++) begin
      op_r(3'(f), 1'b0, 5'd3, 5'd1, 5'd2);
      store_slot(5'd3);
    end
    op_r(3'd0, 1'b1, 5'd3, 5'd1, 5'd2);
    store_slot(5'd3);
    op_r(3'd5, 1'b1, 5'd3, 5'd1, 5'd2);
    store_slot(5'd3);
    for (int f = 0; f < 8; f++) begin
      imm = 12'($random(seed));
      if (f == 1 || f == 5) begin
        imm[11:5] = 7'd0;
      end
      op_i(3'(f), 5'd4, 5'd1, imm);
      store_slot(5'd4);
    end
    imm = {7'h20, 5'($random(seed))};
    op_i(3'd5, 5'd4, 5'd1, imm);
    store_slot(5'd4);
    run_prog("alu");
  endtask

  task automatic test_ldst();
    riscv_pkg::word_t w;
    start_prog();
    // Byte 0 and half 1 negative, half 0 positive.
    w = (riscv_pkg::word_t'($random(seed)) | 32'h8000_0080) & 32'hFFFF_7FFF;
    load_const(5'd5, w);
    store(3'd2, 5'd5, 12'h200);
    store(3'd0, 5'd5, 12'h205);
    store(3'd1, 5'd5, 12'h20A);
    store(3'd0, 5'd5, 12'h20F);
    store(3'd1, 5'd5, 12'h210);
    for (int k = 0; k < 4; k++) begin
      load(3'd0, 5'd6, 12'(12'h200 + k));
      store_slot(5'd6);
      load(3'd4, 5'd6, 12'(12'h200 + k));
      store_slot(5'd6);
    end
    for (int k = 0; k < 4; k += 2) begin
      load(3'd1, 5'd6, 12'(12'h200 + k));
      store_slot(5'd6);
      load(3'd5, 5'd6, 12'(12'h200 + k));
      store_slot(5'd6);
    end
    load(3'd2, 5'd6, 12'h200);
    store_slot(5'd6);
    load(3'd0, 5'd6, 12'h0C3);
    store_slot(5'd6);
    run_prog("ldst");
  endtask

  task automatic test_branch();
    logic [2:0]       kinds [6];
    logic [4:0]       ra;
    logic [4:0]       rb;
    riscv_pkg::word_t a0;
    kinds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    start_prog();
    load_const(5'd1, 32'hFFFF_FFFB);
    load_const(5'd2, 32'd3);
    load_const(5'd3, 32'd3);
    foreach (kinds[k]) begin
      for (int p = 0; p < 3; p++) begin
        ra = (p == 0) ? 5'd1 : 5'd2;
        rb = (p == 0) ? 5'd2 : (p == 1) ? 5'd3 : 5'd1;
        op_i(3'd0, 5'd7, 5'd0, 12'd0);
        emit({1'b0, 6'd0, rb, ra, kinds[k], 4'd4, 1'b0, riscv_pkg::BRANCH});
        emit({12'd1, 5'd0, 3'd0, 5'd7, riscv_pkg::OP_IMM});
        set_reg(5'd7, branch_ref(kinds[k], exp_reg[ra], exp_reg[rb]) ? 32'd0 : 32'd1);
        store_slot(5'd7);
      end
    end
    op_i(3'd0, 5'd9, 5'd0, 12'd0);
    set_reg(5'd8, pc_now() + 32'd4);
    emit({1'b0, 10'd4, 1'b0, 8'd0, 5'd8, riscv_pkg::JAL});
    emit({12'd1, 5'd0, 3'd0, 5'd9, riscv_pkg::OP_IMM});
    store_slot(5'd8);
    store_slot(5'd9);
    op_i(3'd0, 5'd12, 5'd0, 12'd0);
    // Target has bit 0 set, the jump must clear it.
    a0 = pc_now();
    load_const(5'd10, a0 + 32'd17);
    set_reg(5'd11, a0 + 32'd12);
    emit({12'd0, 5'd10, 3'd0, 5'd11, riscv_pkg::JALR});
    emit({12'd1, 5'd0, 3'd0, 5'd12, riscv_pkg::OP_IMM});
    store_slot(5'd11);
    store_slot(5'd12);
    run_prog("branch");
  endtask

  task automatic test_upper();
    logic [19:0] imm;
    start_prog();
    imm = 20'($random(seed));
    emit({imm, 5'd13, riscv_pkg::LUI});
    set_reg(5'd13, {imm, 12'd0});
    imm = 20'($random(seed));
    set_reg(5'd14, pc_now() + {imm, 12'd0});
    emit({imm, 5'd14, riscv_pkg::AUIPC});
    store_slot(5'd13);
    store_slot(5'd14);
    run_prog("upper");
  endtask

  task automatic test_illegal();
    start_prog();
    load_const(5'd1, $random(seed));
    load_const(5'd15, 32'h1234_5678);
    ill_exp.push_back(pc_now());
    emit({7'h01, 5'd1, 5'd1, 3'd0, 5'd15, riscv_pkg::OP});
    ill_exp.push_back(pc_now());
    emit({12'h040, 5'd0, 3'd3, 5'd15, riscv_pkg::LOAD});
    ill_exp.push_back(pc_now());
    emit({25'd0, riscv_pkg::SYSTEM});
    store_slot(5'd15);
    run_prog("illegal");
  endtask

  initial begin
    rst_i = 1'b1;
    errors = 0;
    req_errors = 0;
    seed = 44;
    for (int i = 0; i < 256; i++) begin
      imem[i] = NOP;
    end
    test_alu();
    test_ldst();
    test_branch();
    test_upper();
    test_illegal();
    errors += req_errors;
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- list.f
src/riscv_pkg.sv
src/lsu_core_if.sv
src/decoder_riscv.sv
src/alu_riscv.sv
src/rf_riscv.sv
src/lsu_riscv.sv
src/riscv_core.sv
tb/tb_riscv_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_riscv_core
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; true
	@cat $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
